/* apb_delay_top.f */
+incdir+bench
common/apb_pkg.sv
common/delay_pkg.sv
hdl/apb_requester.sv
apb_delayer/apb_delayer.sv
hdl/apb_reg_slave.sv
hdl/apb_delay_top.sv
bench/apb_delay_tb.sv

/* apb_delayer/apb_delayer.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_delayer #(
    parameter delay_pkg::ratio_t delay_ratio = 16'd2048
) (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t up_req,
    output apb_pkg::apb_rsp_t up_rsp,
    output apb_pkg::apb_req_t dn_req,
    input  apb_pkg::apb_rsp_t dn_rsp
);
    import apb_pkg::*;
    import delay_pkg::*;

    delay_state_t          state;
    logic [31:0]           acc;
    logic [31:0]           countdown;
    logic [data_width-1:0] prdata_q;
    logic                  pslverr_q;
    logic                  block;
    logic                  start;
    logic                  dn_done;
    logic                  release_rsp;

    // setup phase of a new upstream transfer
    assign start = (state == idle) && up_req.psel && !up_req.penable;

    // downstream finished, the slave answered in this cycle
    assign dn_done = (state == active) && dn_rsp.pready;

    // scaled wait paid off
    assign release_rsp = (state == delay) && (countdown == '0);

    // everything passes through except the select, which is held off
    // once the slave has answered so it never sees a second access
    always_comb begin
        dn_req         = up_req;
        dn_req.psel    = up_req.psel && !block;
        dn_req.penable = up_req.penable && !block;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= active;
                    end
                end
                active: begin
                    if (dn_rsp.pready) begin
                        state <= delay;
                    end
                end
                delay: begin
                    if (countdown == '0) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // accumulate ratio per downstream wait cycle, then count down the integer part
    always_ff @(posedge clock) begin
        if (reset) begin
            acc       <= '0;
            countdown <= '0;
        end else begin
            if (start) begin
                acc <= '0;
            end else if ((state == active) && !dn_rsp.pready) begin
                acc <= acc + 32'(delay_ratio);
            end

            if (dn_done) begin
                countdown <= acc >> ratio_frac_bits;
            end else if ((state == delay) && (countdown != '0)) begin
                countdown <= countdown - 32'd1;
            end
        end
    end

    // slave answer parked until release
    always_ff @(posedge clock) begin
        if (dn_done) begin
            prdata_q  <= dn_rsp.prdata;
            pslverr_q <= dn_rsp.pslverr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            block <= 1'b0;
        end else if (dn_done) begin
            block <= 1'b1;
        end else if (!up_req.psel) begin
            block <= 1'b0;
        end
    end

    // one-cycle registered response upstream, zero data otherwise
    always_ff @(posedge clock) begin
        if (reset) begin
            up_rsp <= '0;
        end else begin
            up_rsp.pready  <= release_rsp;
            up_rsp.prdata  <= release_rsp ? prdata_q : '0;
            up_rsp.pslverr <= release_rsp && pslverr_q;
        end
    end

    // slave must stay deselected while the delay runs
    a_no_sel_in_delay: assert property (
        @(posedge clock) disable iff (reset)
        (state == delay) |-> !dn_req.psel
    ) else $error("downstream select during delay");

endmodule

`default_nettype wire

/* bench/apb_delay_tests.svh */
`ifndef apb_delay_tests_svh
`define apb_delay_tests_svh

task automatic read_after_reset();
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    check_value("reset_state", 32'd1, 32'(cmd_ready));
    check_value("reset_state", 32'd0, 32'(rsp_valid));
    do_cmd(32'h0, 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("reset_state", 32'd0, rdata);
    check_value("reset_state", 32'd0, 32'(err));
endtask

task automatic write_all_read_back();
    logic [31:0] data;
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    for (int i = 0; i < tb_num_regs; i++) begin
        data = $random(seed);
        do_cmd(32'(i * 4), 1'b1, data, 4'hf, rdata, err, cycles);
        check_value("write_read", 32'd0, 32'(err));
        shadow[i] = data;
    end
    for (int i = 0; i < tb_num_regs; i++) begin
        do_cmd(32'(i * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
        check_value("write_read", shadow[i], rdata);
        check_value("write_read", 32'd0, 32'(err));
    end
endtask

task automatic strobe_write_check(input int idx, input logic [3:0] strb);
    logic [31:0] data;
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    data = $random(seed);
    do_cmd(32'(idx * 4), 1'b1, data, strb, rdata, err, cycles);
    check_value("byte_strobes", 32'd0, 32'(err));
    shadow[idx] = merge_bytes(shadow[idx], data, strb);
    do_cmd(32'(idx * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("byte_strobes", shadow[idx], rdata);
endtask

task automatic partial_strobe_writes();
    strobe_write_check(5, 4'b0101);
    strobe_write_check(9, 4'b1000);
    strobe_write_check(12, 4'b0110);
endtask

task automatic out_of_range_access();
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    do_cmd(32'(20 * 4), 1'b1, $random(seed), 4'hf, rdata, err, cycles);
    check_value("error_response", 32'd1, 32'(err));
    do_cmd(32'(20 * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("error_response", 32'd1, 32'(err));
    check_value("error_response", 32'd0, rdata);
    // low index bits of 20 would alias register 4
    do_cmd(32'(4 * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("error_response", shadow[4], rdata);
    do_cmd(32'(3 * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("error_response", shadow[3], rdata);
    check_value("error_response", 32'd0, 32'(err));
endtask

task automatic delay_case(input int w);
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    int          expected_cycles;
    expected_cycles = 5 + w + ((w * int'(tb_ratio)) >> ratio_frac_bits);
    do_cmd(32'(wait_reg_addr), 1'b1, 32'(w), 4'hf, rdata, err, cycles);
    check_value("delay_scaling", 32'd0, 32'(err));
    do_cmd(32'(1 * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("delay_scaling", 32'(expected_cycles), 32'(cycles));
    check_value("delay_scaling", shadow[1], rdata);
    do_cmd(32'(wait_reg_addr), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("delay_scaling", 32'(w), rdata);
endtask

task automatic wait_state_latency();
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    delay_case(0);
    delay_case(3);
    delay_case(6);
    // back to zero wait states
    do_cmd(32'(wait_reg_addr), 1'b1, 32'h0, 4'hf, rdata, err, cycles);
endtask

task automatic hold_under_back_pressure();
    rsp_t        held;
    logic [31:0] rdata;
    logic [31:0] data;
    logic        err;
    int          cycles;
    start_cmd(32'(7 * 4), 1'b0, 32'h0, 4'h0);
    wait_valid(cycles);
    held = rsp;
    check_value("back_pressure", shadow[7], held.rdata);
    check_value("back_pressure", 32'd0, 32'(held.err));
    repeat (10) begin
        @(negedge clock);
        check_value("back_pressure", 32'd1, 32'(rsp_valid));
        check_value("back_pressure", held.rdata, rsp.rdata);
        check_value("back_pressure", 32'(held.err), 32'(rsp.err));
        check_value("back_pressure", 32'd0, 32'(cmd_ready));
    end
    accept_result(rdata, err);
    check_value("back_pressure", shadow[7], rdata);
    data = $random(seed);
    do_cmd(32'(7 * 4), 1'b1, data, 4'hf, rdata, err, cycles);
    shadow[7] = data;
    do_cmd(32'(7 * 4), 1'b0, 32'h0, 4'h0, rdata, err, cycles);
    check_value("back_pressure", shadow[7], rdata);
endtask

`endif

/* bench/apb_delay_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_delay_tb;
    import apb_pkg::*;
    import delay_pkg::*;

    localparam int     clk_period    = 40;
    localparam ratio_t tb_ratio      = 16'd2048;
    localparam int     tb_num_regs   = 15;
    localparam int     wait_reg_addr = tb_num_regs * 4;

    // worst command is a read at W = 6 plus the drive and accept edges
    localparam int max_cmd_cycles  = 5 + 6 + 12 + 3;
    localparam int num_cmds        = 60;
    localparam int watchdog_cycles = 2 * (4 + num_cmds * max_cmd_cycles + 10);

    logic clock;
    logic reset;
    logic cmd_valid;
    cmd_t cmd;
    logic cmd_ready;
    logic rsp_valid;
    rsp_t rsp;
    logic rsp_ready;

    // expected register contents
    logic [data_width-1:0] shadow [tb_num_regs];
    int                    seed;

    apb_delay_top #(
        .delay_ratio (tb_ratio),
        .num_regs    (tb_num_regs)
    ) u_apb_delay_top (
        .clock     (clock),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", test_name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    // called at a falling edge and returns at the falling edge after the handshake
    task automatic start_cmd(input logic [31:0] addr, input logic write,
                             input logic [31:0] wdata, input logic [3:0] strb);
        while (!cmd_ready) begin
            @(negedge clock);
        end
        cmd_valid = 1'b1;
        cmd.addr  = addr;
        cmd.write = write;
        cmd.wdata = wdata;
        cmd.strb  = strb;
        @(negedge clock);
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    // cycles counts rising edges after the command handshake
    task automatic wait_valid(output int cycles);
        cycles = 0;
        while (!rsp_valid) begin
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic accept_result(output logic [31:0] rdata, output logic err);
        rdata     = rsp.rdata;
        err       = rsp.err;
        rsp_ready = 1'b1;
        @(negedge clock);
        rsp_ready = 1'b0;
    endtask

    task automatic do_cmd(input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          output logic [31:0] rdata, output logic err,
                          output int cycles);
        start_cmd(addr, write, wdata, strb);
        wait_valid(cycles);
        accept_result(rdata, err);
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                                input logic [31:0] new_value,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_value;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_value[8*b +: 8];
            end
        end
        return result;
    endfunction

    `include "apb_delay_tests.svh"

    initial begin
        seed      = 63;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rsp_ready = 1'b0;
        for (int i = 0; i < tb_num_regs; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(negedge clock);
        reset = 1'b0;

        read_after_reset();
        write_all_read_back();
        partial_strobe_writes();
        out_of_range_access();
        wait_state_latency();
        hold_under_back_pressure();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* common/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    // bus geometry, one word per access
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // requester-side drive of one APB port
    typedef struct packed {
        logic [addr_width-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic [2:0]            pprot;
        logic                  pwrite;
        logic [data_width-1:0] pwdata;
        logic [strb_width-1:0] pstrb;
    } apb_req_t;

    // completer-side reply
    typedef struct packed {
        logic                  pready;
        logic [data_width-1:0] prdata;
        logic                  pslverr;
    } apb_rsp_t;

    // one register command from the core side
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic                  write;
        logic [data_width-1:0] wdata;
        logic [strb_width-1:0] strb;
    } cmd_t;

    // result handed back to the core side
    typedef struct packed {
        logic [data_width-1:0] rdata;
        logic                  err;
    } rsp_t;

endpackage

`default_nettype wire

/* common/delay_pkg.sv */
`default_nettype none

package delay_pkg;

    // fraction bits of the clock ratio, 1.0 == 1024
    localparam int ratio_frac_bits = 10;

    // unsigned 6.10 fixed point, core cycles per device cycle
    typedef logic [15:0] ratio_t;

    // idle until a setup phase shows up
    // active while the downstream access runs
    // delay while the scaled wait time is paid off
    typedef enum logic [1:0] {
        idle,
        active,
        delay
    } delay_state_t;

endpackage

`default_nettype wire

/* hdl/apb_delay_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_delay_top #(
    parameter delay_pkg::ratio_t delay_ratio = 16'd2048,
    parameter int                num_regs    = 15
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          cmd_valid,
    input  apb_pkg::cmd_t cmd,
    output logic          cmd_ready,
    output logic          rsp_valid,
    output apb_pkg::rsp_t rsp,
    input  logic          rsp_ready
);
    import apb_pkg::*;

    // core side of the delayer
    apb_req_t up_req;
    apb_rsp_t up_rsp;

    // device side of the delayer
    apb_req_t dn_req;
    apb_rsp_t dn_rsp;

    apb_requester u_requester (
        .clock     (clock),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .up_req    (up_req),
        .up_rsp    (up_rsp)
    );

    apb_delayer #(
        .delay_ratio (delay_ratio)
    ) u_delayer (
        .clock  (clock),
        .reset  (reset),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .dn_req (dn_req),
        .dn_rsp (dn_rsp)
    );

    apb_reg_slave #(
        .num_regs (num_regs)
    ) u_slave (
        .clock (clock),
        .reset (reset),
        .req   (dn_req),
        .rsp   (dn_rsp)
    );

endmodule

`default_nettype wire

/* hdl/apb_reg_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_reg_slave #(
    parameter int num_regs = 15
) (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);
    import apb_pkg::*;

    localparam int idx_width = $clog2(num_regs + 1);

    logic [data_width-1:0] regs [num_regs];
    logic [7:0]            wait_states;
    logic [7:0]            wait_cnt;
    logic [addr_width-3:0] word_idx;
    logic [idx_width-1:0]  reg_idx;
    logic                  in_range;
    logic                  is_wait_reg;
    logic                  access;
    logic                  done;
    logic [data_width-1:0] rd_value;

    // word addressing, byte offset ignored
    assign word_idx    = req.paddr[addr_width-1:2];
    assign reg_idx     = word_idx[idx_width-1:0];
    assign in_range    = (word_idx <= num_regs);
    assign is_wait_reg = (word_idx == num_regs);

    assign access = req.psel && req.penable;
    assign done   = access && (wait_cnt == '0);

    always_comb begin
        rd_value = '0;
        if (is_wait_reg) begin
            rd_value = {{(data_width-8){1'b0}}, wait_states};
        end else if (in_range) begin
            rd_value = regs[reg_idx];
        end
    end

    // reply only in the completing cycle
    assign rsp.pready  = done;
    assign rsp.prdata  = (done && !req.pwrite) ? rd_value : '0;
    assign rsp.pslverr = done && !in_range;

    // wait count loaded in setup, so a new wait value applies from the next access
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (req.psel && !req.penable) begin
            wait_cnt <= wait_states;
        end else if (access && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 8'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            wait_states <= '0;
        end else if (done && req.pwrite && in_range) begin
            if (is_wait_reg) begin
                // only the low byte is implemented
                if (req.pstrb[0]) begin
                    wait_states <= req.pwdata[7:0];
                end
            end else begin
                for (int b = 0; b < strb_width; b++) begin
                    if (req.pstrb[b]) begin
                        regs[reg_idx][8*b +: 8] <= req.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // APB framing as seen at the slave, after the delayer's select blocking
    a_enable_needs_sel: assert property (
        @(posedge clock) disable iff (reset)
        req.penable |-> req.psel
    ) else $error("penable without psel at slave");

endmodule

`default_nettype wire

/* hdl/apb_requester.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_requester (
    input  logic              clock,
    input  logic              reset,
    input  logic              cmd_valid,
    input  apb_pkg::cmd_t     cmd,
    output logic              cmd_ready,
    output logic              rsp_valid,
    output apb_pkg::rsp_t     rsp,
    input  logic              rsp_ready,
    output apb_pkg::apb_req_t up_req,
    input  apb_pkg::apb_rsp_t up_rsp
);
    import apb_pkg::*;

    typedef enum logic [1:0] {
        idle,
        setup,
        access,
        hold
    } req_state_t;

    req_state_t state;
    cmd_t       cmd_q;
    logic       psel_q;
    logic       penable_q;
    logic       capture;

    // one command in flight, accept only when fully idle
    assign cmd_ready = (state == idle);

    // completion seen in an access cycle
    assign capture = (state == access) && penable_q && up_rsp.pready;

    // bus drive comes from registers, so it is stable across wait cycles
    always_comb begin
        up_req.paddr   = cmd_q.addr;
        up_req.psel    = psel_q;
        up_req.penable = penable_q;
        up_req.pprot   = 3'b000;
        up_req.pwrite  = cmd_q.write;
        up_req.pwdata  = cmd_q.write ? cmd_q.wdata : '0;
        up_req.pstrb   = cmd_q.write ? cmd_q.strb : '0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= idle;
            psel_q    <= 1'b0;
            penable_q <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_valid) begin
                        state <= setup;
                    end
                end
                // psel rises on leaving this state
                setup: begin
                    psel_q <= 1'b1;
                    state  <= access;
                end
                access: begin
                    if (!penable_q) begin
                        penable_q <= 1'b1;
                    end else if (up_rsp.pready) begin
                        psel_q    <= 1'b0;
                        penable_q <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= hold;
                    end
                end
                hold: begin
                    // result waits here under back-pressure
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
        if (capture) begin
            rsp.rdata <= up_rsp.prdata;
            rsp.err   <= up_rsp.pslverr;
        end
    end

    // address, direction and data hold until the transfer completes
    a_req_stable: assert property (
        @(posedge clock) disable iff (reset)
        (up_req.psel && !up_rsp.pready) |=>
            (up_req.psel &&
             $stable({up_req.paddr, up_req.pwrite, up_req.pwdata, up_req.pstrb}))
    ) else $error("apb request changed before pready");

endmodule

`default_nettype wire
